// ==== common/decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// datapath widths
`define XLEN        64
`define ILEN        32
`define IMM_W       20
`define REG_W       5

// major opcodes kept from rv64i
`define OPC_OP      7'b0110011
`define OPC_OP32    7'b0111011
`define OPC_OPIMM   7'b0010011
`define OPC_OPIMM32 7'b0011011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

// funct7 encodings
`define BASE_F7     7'b0000000
`define ALT_F7      7'b0100000
`define MULDIV_F7   7'b0000001

// dispatch and issue queue ids
`define DQ_INT_BLK      2'd0
`define DQ_MEM_BLK      2'd1
`define DQ_UNKNOWN_BLK  2'd2
`define IQ_ALU          2'd0
`define IQ_MDU          2'd1
`define IQ_MISC         2'd2

`endif

// ==== common/decode_pkg.sv ====
`include "decode_cfg.svh"

package decode_pkg;

    typedef enum logic [4:0] {
        alu_none = 5'd0,
        alu_lui,
        alu_add,
        alu_sub,
        alu_addw,
        alu_subw,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_sllw,
        alu_srlw,
        alu_sraw,
        alu_xor,
        alu_or,
        alu_and,
        alu_slt,
        alu_sltu
    } alu_op_e;

    typedef enum logic [4:0] {
        mdu_none = 5'd0,
        mdu_mul,
        mdu_mulh,
        mdu_mulhsu,
        mdu_mulhu,
        mdu_mulw,
        mdu_div,
        mdu_divu,
        mdu_divw,
        mdu_divuw,
        mdu_rem,
        mdu_remu,
        mdu_remw,
        mdu_remuw
    } mdu_op_e;

    // one micro-op word, view picked by issue queue
    typedef union packed {
        alu_op_e alu;
        mdu_op_e mdu;
    } micop_u;

    typedef enum logic [1:0] {
        int_blk     = `DQ_INT_BLK,
        mem_blk     = `DQ_MEM_BLK,
        unknown_blk = `DQ_UNKNOWN_BLK
    } disp_que_e;

    typedef enum logic [1:0] {
        alu_iq  = `IQ_ALU,
        mdu_iq  = `IQ_MDU,
        misc_iq = `IQ_MISC
    } issue_que_e;

    typedef struct packed {
        logic       is_op;
        logic       is_op32;
        logic       is_opimm;
        logic       is_opimm32;
        logic       is_lui;
        logic       is_auipc;
        logic       is_jal;
        logic       is_jalr;
        logic       is_branch;
        logic       is_load;
        logic       is_store;
        logic       is_muldiv;
        logic       unknown;
        logic [2:0] funct3;
        // inst[30], sub/sra select
        logic       is_alt;
    } inst_class_t;

    typedef struct packed {
        logic [`REG_W-1:0] rd;
        logic [`REG_W-1:0] rs1;
        logic [`REG_W-1:0] rs2;
        logic [2:0]        funct3;
    } inst_fields_t;

    typedef struct packed {
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  npc;
        logic [`IMM_W-1:0] imm20;
        logic              rd_wen;
        logic [`REG_W-1:0] rd_idx;
        logic [`REG_W-1:0] rs1_idx;
        logic [`REG_W-1:0] rs2_idx;
        logic              use_imm;
        logic              is_mv;
        disp_que_e         disp_que;
        issue_que_e        issue_que;
        micop_u            micop;
    } decinfo_t;

endpackage

// ==== decoder/inst_classify.sv ====
`include "decode_cfg.svh"

module inst_classify (
    input  logic [`ILEN-1:0]         i_inst,
    output decode_pkg::inst_class_t  o_class,
    output decode_pkg::inst_fields_t o_fields
);
    import decode_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [5:0]  funct6;
    inst_class_t cls;
    logic        opc_hit;
    logic        bad_low;
    logic        bad_op;
    logic        bad_op32;
    logic        bad_shift;
    logic        bad_mem;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    // rv64 shifts carry a 6-bit shamt, funct6 above it
    assign funct6 = i_inst[31:26];

    always_comb begin
        cls            = '0;
        cls.is_op      = (opcode == `OPC_OP);
        cls.is_op32    = (opcode == `OPC_OP32);
        cls.is_opimm   = (opcode == `OPC_OPIMM);
        cls.is_opimm32 = (opcode == `OPC_OPIMM32);
        cls.is_lui     = (opcode == `OPC_LUI);
        cls.is_auipc   = (opcode == `OPC_AUIPC);
        cls.is_jal     = (opcode == `OPC_JAL);
        cls.is_jalr    = (opcode == `OPC_JALR);
        cls.is_branch  = (opcode == `OPC_BRANCH);
        cls.is_load    = (opcode == `OPC_LOAD);
        cls.is_store   = (opcode == `OPC_STORE);
        cls.is_muldiv  = (cls.is_op || cls.is_op32) && (funct7 == `MULDIV_F7);
        cls.funct3     = funct3;
        cls.is_alt     = i_inst[30];

        opc_hit = cls.is_op | cls.is_op32 | cls.is_opimm | cls.is_opimm32 |
                  cls.is_lui | cls.is_auipc | cls.is_jal | cls.is_jalr |
                  cls.is_branch | cls.is_load | cls.is_store;

        // compressed or reserved encodings
        bad_low = (i_inst[1:0] != 2'b11);

        // op: alt funct7 only for sub and sra
        bad_op = cls.is_op &&
                 !((funct7 == `BASE_F7) || (funct7 == `MULDIV_F7) ||
                   ((funct7 == `ALT_F7) && ((funct3 == 3'b000) || (funct3 == 3'b101))));

        bad_op32 = 1'b0;
        if (cls.is_op32) begin
            case (funct7)
                `BASE_F7:   bad_op32 = !(funct3 inside {3'b000, 3'b001, 3'b101});
                `ALT_F7:    bad_op32 = !(funct3 inside {3'b000, 3'b101});
                `MULDIV_F7: bad_op32 = (funct3 inside {3'b001, 3'b010, 3'b011});
                default:    bad_op32 = 1'b1;
            endcase
        end

        bad_shift = 1'b0;
        if (cls.is_opimm) begin
            if (funct3 == 3'b001) begin
                bad_shift = (funct6 != 6'b000000);
            end else if (funct3 == 3'b101) begin
                bad_shift = !((funct6 == 6'b000000) || (funct6 == 6'b010000));
            end
        end else if (cls.is_opimm32) begin
            case (funct3)
                3'b000:  bad_shift = 1'b0;
                3'b001:  bad_shift = (funct7 != `BASE_F7);
                3'b101:  bad_shift = !((funct7 == `BASE_F7) || (funct7 == `ALT_F7));
                // only addiw and the word shifts exist here
                default: bad_shift = 1'b1;
            endcase
        end

        // branch 010/011, load 111, store above sd
        bad_mem = (cls.is_branch && (funct3[2:1] == 2'b01)) ||
                  (cls.is_load && (funct3 == 3'b111)) ||
                  (cls.is_store && funct3[2]);

        cls.unknown = bad_low | !opc_hit | bad_op | bad_op32 | bad_shift | bad_mem;
    end

    assign o_class = cls;

    assign o_fields.rd     = i_inst[11:7];
    assign o_fields.rs1    = i_inst[19:15];
    assign o_fields.rs2    = i_inst[24:20];
    assign o_fields.funct3 = funct3;

endmodule

// ==== decoder/imm_gen.sv ====
`include "decode_cfg.svh"

module imm_gen (
    input  logic [`ILEN-1:0]        i_inst,
    input  decode_pkg::inst_class_t i_class,
    output logic [`IMM_W-1:0]       o_imm20
);
    import decode_pkg::*;

    logic              is_shift;
    logic [`IMM_W-1:0] imm_u;
    logic [`IMM_W-1:0] imm_i;
    logic [`IMM_W-1:0] imm_sh;
    logic [`IMM_W-1:0] imm_s;
    logic [`IMM_W-1:0] imm_b;
    logic [`IMM_W-1:0] imm_j;

    assign is_shift = (i_class.is_opimm || i_class.is_opimm32) &&
                      ((i_class.funct3 == 3'b001) || (i_class.funct3 == 3'b101));

    // lui/auipc, shifted left by 12 at use
    assign imm_u  = i_inst[31:12];
    assign imm_i  = {{8{i_inst[31]}}, i_inst[31:20]};
    assign imm_sh = {14'd0, i_inst[25:20]};
    assign imm_s  = {{8{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    // offset[12:1] sign-extended, low zero appended
    assign imm_b  = {{7{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                     i_inst[11:8], 1'b0};
    // offset[20:1], sign bit on top
    assign imm_j  = {i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21]};

    always_comb begin
        if (i_class.is_lui || i_class.is_auipc) begin
            o_imm20 = imm_u;
        end else if (i_class.is_branch) begin
            o_imm20 = imm_b;
        end else if (i_class.is_store) begin
            o_imm20 = imm_s;
        end else if (i_class.is_jal) begin
            o_imm20 = imm_j;
        end else if (is_shift) begin
            o_imm20 = imm_sh;
        end else if (i_class.is_load || i_class.is_jalr ||
                     i_class.is_opimm || i_class.is_opimm32) begin
            o_imm20 = imm_i;
        end else begin
            o_imm20 = '0;
        end
    end

endmodule

// ==== decoder/micop_gen.sv ====
module micop_gen (
    input  decode_pkg::inst_class_t  i_class,
    input  decode_pkg::inst_fields_t i_fields,
    output decode_pkg::micop_u       o_micop,
    output decode_pkg::issue_que_e   o_issue_que,
    output decode_pkg::disp_que_e    o_disp_que
);
    import decode_pkg::*;

    alu_op_e alu_op;
    mdu_op_e mdu_op;
    logic    legal;

    assign legal = !i_class.unknown;

    always_comb begin
        alu_op = alu_none;
        if (legal && !i_class.is_muldiv) begin
            if (i_class.is_lui) begin
                alu_op = alu_lui;
            end else if (i_class.is_op || i_class.is_opimm) begin
                case (i_fields.funct3)
                    // addi has no sub form, bit 30 is immediate there
                    3'b000: alu_op = (i_class.is_op && i_class.is_alt) ? alu_sub : alu_add;
                    3'b001: alu_op = alu_sll;
                    3'b010: alu_op = alu_slt;
                    3'b011: alu_op = alu_sltu;
                    3'b100: alu_op = alu_xor;
                    3'b101: alu_op = i_class.is_alt ? alu_sra : alu_srl;
                    3'b110: alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end else if (i_class.is_op32 || i_class.is_opimm32) begin
                case (i_fields.funct3)
                    3'b000: alu_op = (i_class.is_op32 && i_class.is_alt) ? alu_subw : alu_addw;
                    3'b001: alu_op = alu_sllw;
                    3'b101: alu_op = i_class.is_alt ? alu_sraw : alu_srlw;
                    default: alu_op = alu_none;
                endcase
            end
        end
    end

    always_comb begin
        mdu_op = mdu_none;
        if (legal && i_class.is_muldiv) begin
            case ({i_class.is_op32, i_fields.funct3})
                4'b0_000: mdu_op = mdu_mul;
                4'b0_001: mdu_op = mdu_mulh;
                4'b0_010: mdu_op = mdu_mulhsu;
                4'b0_011: mdu_op = mdu_mulhu;
                4'b0_100: mdu_op = mdu_div;
                4'b0_101: mdu_op = mdu_divu;
                4'b0_110: mdu_op = mdu_rem;
                4'b0_111: mdu_op = mdu_remu;
                4'b1_000: mdu_op = mdu_mulw;
                4'b1_100: mdu_op = mdu_divw;
                4'b1_101: mdu_op = mdu_divuw;
                4'b1_110: mdu_op = mdu_remw;
                4'b1_111: mdu_op = mdu_remuw;
                default:  mdu_op = mdu_none;
            endcase
        end
    end

    always_comb begin
        o_micop = '0;
        if (alu_op != alu_none) begin
            o_issue_que = alu_iq;
            o_micop.alu = alu_op;
        end else if (mdu_op != mdu_none) begin
            o_issue_que = mdu_iq;
            o_micop.mdu = mdu_op;
        end else begin
            // branches, jumps, auipc, memory and unknown
            o_issue_que = misc_iq;
        end
    end

    // unknown first, so a bad load never reaches the memory block
    assign o_disp_que = i_class.unknown ? unknown_blk :
                        (i_class.is_load || i_class.is_store) ? mem_blk :
                        int_blk;

endmodule

// ==== decoder/operand_gen.sv ====
`include "decode_cfg.svh"

module operand_gen (
    input  decode_pkg::inst_class_t  i_class,
    input  decode_pkg::inst_fields_t i_fields,
    input  logic [`IMM_W-1:0]        i_imm20,
    output logic                     o_rd_wen,
    output logic [`REG_W-1:0]        o_rd_idx,
    output logic [`REG_W-1:0]        o_rs1_idx,
    output logic [`REG_W-1:0]        o_rs2_idx,
    output logic                     o_use_imm,
    output logic                     o_is_mv
);
    import decode_pkg::*;

    logic writes_rd;
    logic reads_rs1;
    logic reads_rs2;
    logic is_addi;

    assign writes_rd = i_class.is_lui | i_class.is_auipc | i_class.is_jal | i_class.is_jalr |
                       i_class.is_op | i_class.is_op32 | i_class.is_opimm |
                       i_class.is_opimm32 | i_class.is_load;

    assign reads_rs1 = i_class.is_jalr | i_class.is_branch | i_class.is_load |
                       i_class.is_store | i_class.is_op | i_class.is_op32 |
                       i_class.is_opimm | i_class.is_opimm32;

    assign reads_rs2 = i_class.is_branch | i_class.is_store | i_class.is_op | i_class.is_op32;

    // x0 writes are dropped here
    assign o_rd_wen  = writes_rd && !i_class.unknown && (i_fields.rd != '0);
    assign o_rd_idx  = o_rd_wen ? i_fields.rd : '0;
    assign o_rs1_idx = reads_rs1 ? i_fields.rs1 : '0;
    assign o_rs2_idx = reads_rs2 ? i_fields.rs2 : '0;

    // rs2 operand replaced by imm20
    assign o_use_imm = i_class.is_opimm | i_class.is_opimm32 | i_class.is_lui;

    // addi rd, rd, 0 style moves
    assign is_addi = i_class.is_opimm && (i_class.funct3 == 3'b000);
    assign o_is_mv = is_addi && (i_fields.rd == i_fields.rs1) && (i_imm20 == '0);

endmodule

// ==== src/decode_stage.sv ====
`include "decode_cfg.svh"

module decode_stage (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_valid,
    input  logic [`ILEN-1:0]     i_inst,
    input  logic [`XLEN-1:0]     i_inst_pc,
    input  logic [`XLEN-1:0]     i_inst_npc,
    output logic                 o_valid,
    output decode_pkg::decinfo_t o_decinfo
);
    import decode_pkg::*;

    inst_class_t       cls;
    inst_fields_t      fields;
    logic [`IMM_W-1:0] imm20;
    micop_u            micop;
    issue_que_e        issue_que;
    disp_que_e         disp_que;
    logic              rd_wen;
    logic [`REG_W-1:0] rd_idx;
    logic [`REG_W-1:0] rs1_idx;
    logic [`REG_W-1:0] rs2_idx;
    logic              use_imm;
    logic              is_mv;
    decinfo_t          decinfo_d;

    inst_classify inst_classify_inst (
        .i_inst   (i_inst),
        .o_class  (cls),
        .o_fields (fields)
    );

    imm_gen imm_gen_inst (
        .i_inst  (i_inst),
        .i_class (cls),
        .o_imm20 (imm20)
    );

    micop_gen micop_gen_inst (
        .i_class     (cls),
        .i_fields    (fields),
        .o_micop     (micop),
        .o_issue_que (issue_que),
        .o_disp_que  (disp_que)
    );

    operand_gen operand_gen_inst (
        .i_class   (cls),
        .i_fields  (fields),
        .i_imm20   (imm20),
        .o_rd_wen  (rd_wen),
        .o_rd_idx  (rd_idx),
        .o_rs1_idx (rs1_idx),
        .o_rs2_idx (rs2_idx),
        .o_use_imm (use_imm),
        .o_is_mv   (is_mv)
    );

    always_comb begin
        decinfo_d.pc        = i_inst_pc;
        decinfo_d.npc       = i_inst_npc;
        decinfo_d.imm20     = imm20;
        decinfo_d.rd_wen    = rd_wen;
        decinfo_d.rd_idx    = rd_idx;
        decinfo_d.rs1_idx   = rs1_idx;
        decinfo_d.rs2_idx   = rs2_idx;
        decinfo_d.use_imm   = use_imm;
        decinfo_d.is_mv     = is_mv;
        decinfo_d.disp_que  = disp_que;
        decinfo_d.issue_que = issue_que;
        decinfo_d.micop     = micop;
    end

    // record holds until the next strobe
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid   <= 1'b0;
            o_decinfo <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_decinfo <= decinfo_d;
            end
        end
    end

endmodule

// ==== dv/decode_stage_assert.sv ====
module decode_stage_assert (
    input logic                 i_clk,
    input logic                 i_rst,
    input logic                 i_valid,
    input logic                 o_valid,
    input decode_pkg::decinfo_t o_decinfo
);
    import decode_pkg::*;

    // output register cleared by reset
    assert property (@(posedge i_clk) i_rst |=> !o_valid)
        else $error("o_valid high right after reset");

    // valid delayed by exactly one stage
    assert property (@(posedge i_clk) disable iff (i_rst) i_valid |=> o_valid)
        else $error("o_valid missing one cycle after i_valid");

    assert property (@(posedge i_clk) disable iff (i_rst) !i_valid |=> !o_valid)
        else $error("o_valid high without i_valid");

    assert property (@(posedge i_clk) disable iff (i_rst)
        (o_decinfo.issue_que == mdu_iq) |-> (o_decinfo.disp_que == int_blk))
        else $error("mdu issue queue outside the integer block");

endmodule

bind decode_stage decode_stage_assert decode_stage_assert_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (i_valid),
    .o_valid   (o_valid),
    .o_decinfo (o_decinfo)
);

// ==== dv/decode_stage_tb.sv ====
`include "decode_cfg.svh"

module decode_stage_tb;
    import decode_pkg::*;

    localparam int ITEMS     = 300;
    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT   = NUM_TESTS * ITEMS + 100;

    logic              i_clk;
    logic              i_rst;
    logic              i_valid;
    logic [`ILEN-1:0]  i_inst;
    logic [`XLEN-1:0]  i_inst_pc;
    logic [`XLEN-1:0]  i_inst_npc;
    logic              o_valid;
    decinfo_t          o_decinfo;
    decinfo_t          exp_q[$];
    decinfo_t          held;
    integer            seed;
    int                cycles;
    int                errors;
    int                test_errs;
    int                checked;
    logic [`XLEN-1:0]  pc;

    decode_stage decode_stage_inst (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_valid    (i_valid),
        .i_inst     (i_inst),
        .i_inst_pc  (i_inst_pc),
        .i_inst_npc (i_inst_npc),
        .o_valid    (o_valid),
        .o_decinfo  (o_decinfo)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("run stopped, cycle limit %0d reached", TIMEOUT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // expected record built straight from the decode rules
    function automatic decinfo_t ref_decode(input logic [31:0] w, input logic [63:0] pc_v);
        decinfo_t d;
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        logic op, op32, opi, opi32, lui, auipc, jal, jalr, br, ld, st, md, unk, sh;
        alu_op_e a;
        mdu_op_e m;
        opc = w[6:0];
        f7 = w[31:25];
        f3 = w[14:12];
        op = (opc == `OPC_OP);
        op32 = (opc == `OPC_OP32);
        opi = (opc == `OPC_OPIMM);
        opi32 = (opc == `OPC_OPIMM32);
        lui = (opc == `OPC_LUI);
        auipc = (opc == `OPC_AUIPC);
        jal = (opc == `OPC_JAL);
        jalr = (opc == `OPC_JALR);
        br = (opc == `OPC_BRANCH);
        ld = (opc == `OPC_LOAD);
        st = (opc == `OPC_STORE);
        md = (op || op32) && (f7 == 7'h01);
        unk = (w[1:0] != 2'b11) ||
              !(op | op32 | opi | opi32 | lui | auipc | jal | jalr | br | ld | st) ||
              (op && !(f7 == 7'h00 || f7 == 7'h01 ||
                       (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))) ||
              (op32 && ((f7 == 7'h00) ? !(f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) :
                        (f7 == 7'h20) ? !(f3 == 3'd0 || f3 == 3'd5) :
                        (f7 == 7'h01) ? (f3 == 3'd1 || f3 == 3'd2 || f3 == 3'd3) : 1'b1)) ||
              (opi && ((f3 == 3'd1 && w[31:26] != 6'd0) ||
                       (f3 == 3'd5 && w[31:26] != 6'd0 && w[31:26] != 6'b010000))) ||
              (opi32 && (!(f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) ||
                         (f3 == 3'd1 && f7 != 7'h00) ||
                         (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20))) ||
              (br && f3[2:1] == 2'b01) || (ld && f3 == 3'd7) || (st && f3[2]);
        sh = (opi || opi32) && (f3 == 3'd1 || f3 == 3'd5);
        a = alu_none;
        m = mdu_none;
        if (!unk && lui) a = alu_lui;
        if (!unk && !md && (op || opi)) begin
            case (f3)
                3'd0: a = (op && w[30]) ? alu_sub : alu_add;
                3'd1: a = alu_sll;
                3'd2: a = alu_slt;
                3'd3: a = alu_sltu;
                3'd4: a = alu_xor;
                3'd5: a = w[30] ? alu_sra : alu_srl;
                3'd6: a = alu_or;
                default: a = alu_and;
            endcase
        end
        if (!unk && !md && (op32 || opi32)) begin
            if (f3 == 3'd0) a = (op32 && w[30]) ? alu_subw : alu_addw;
            if (f3 == 3'd1) a = alu_sllw;
            if (f3 == 3'd5) a = w[30] ? alu_sraw : alu_srlw;
        end
        if (!unk && md && op) begin
            case (f3)
                3'd0: m = mdu_mul;
                3'd1: m = mdu_mulh;
                3'd2: m = mdu_mulhsu;
                3'd3: m = mdu_mulhu;
                3'd4: m = mdu_div;
                3'd5: m = mdu_divu;
                3'd6: m = mdu_rem;
                default: m = mdu_remu;
            endcase
        end
        if (!unk && md && op32) begin
            if (f3 == 3'd0) m = mdu_mulw;
            if (f3 == 3'd4) m = mdu_divw;
            if (f3 == 3'd5) m = mdu_divuw;
            if (f3 == 3'd6) m = mdu_remw;
            if (f3 == 3'd7) m = mdu_remuw;
        end
        d = '0;
        d.pc = pc_v;
        d.npc = pc_v + 64'd4;
        if (lui || auipc) d.imm20 = w[31:12];
        else if (br) d.imm20 = {{7{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        else if (st) d.imm20 = {{8{w[31]}}, w[31:25], w[11:7]};
        else if (jal) d.imm20 = {w[31], w[19:12], w[20], w[30:21]};
        else if (sh) d.imm20 = {14'd0, w[25:20]};
        else if (ld || jalr || opi || opi32) d.imm20 = {{8{w[31]}}, w[31:20]};
        d.rd_wen = !unk && (w[11:7] != 5'd0) &&
                   (lui | auipc | jal | jalr | op | op32 | opi | opi32 | ld);
        d.rd_idx = d.rd_wen ? w[11:7] : 5'd0;
        d.rs1_idx = (jalr | br | ld | st | op | op32 | opi | opi32) ? w[19:15] : 5'd0;
        d.rs2_idx = (br | st | op | op32) ? w[24:20] : 5'd0;
        d.use_imm = opi | opi32 | lui;
        d.is_mv = opi && (f3 == 3'd0) && (w[11:7] == w[19:15]) && (d.imm20 == '0);
        d.disp_que = unk ? unknown_blk : (ld || st) ? mem_blk : int_blk;
        if (a != alu_none) begin
            d.issue_que = alu_iq;
            d.micop.alu = a;
        end else if (m != mdu_none) begin
            d.issue_que = mdu_iq;
            d.micop.mdu = m;
        end else begin
            d.issue_que = misc_iq;
        end
        return d;
    endfunction

    // kind 0 alu, 1 muldiv, 2 immediates, 3 unknown, 4 mix
    task automatic gen_inst(input int kind, output logic [31:0] w);
        logic [31:0] s;
        int k;
        w = $random(seed);
        s = $random(seed);
        k = (kind == 4) ? int'(s[31:30]) : kind;
        if (k == 0) begin
            w[6:0] = (s[1:0] == 2'd0) ? `OPC_OP : (s[1:0] == 2'd1) ? `OPC_OP32 :
                     (s[1:0] == 2'd2) ? `OPC_OPIMM : `OPC_OPIMM32;
            if (s[0]) w[14:12] = s[3] ? 3'd0 : (s[4] ? 3'd1 : 3'd5);
            if (s[1:0] != 2'd2 || w[13:12] == 2'b01)
                w[31:25] = (s[2] && w[14:12] != 3'd1) ? `ALT_F7 : `BASE_F7;
            if (s[1:0] == 2'd0 && w[14:12] != 3'd0 && w[14:12] != 3'd5) w[31:25] = `BASE_F7;
            if (s[1:0] == 2'd2 && s[7:5] == 3'd0) begin
                w[14:12] = 3'd0;
                w[19:15] = w[11:7];
                w[31:20] = 12'd0;
            end
        end else if (k == 1) begin
            w[6:0] = s[0] ? `OPC_OP32 : `OPC_OP;
            w[31:25] = `MULDIV_F7;
        end else if (k == 2) begin
            case (s[2:0])
                3'd1: w[6:0] = `OPC_STORE;
                3'd2: w[6:0] = `OPC_BRANCH;
                3'd3: w[6:0] = `OPC_JAL;
                3'd4: w[6:0] = `OPC_JALR;
                3'd5: w[6:0] = `OPC_LUI;
                3'd6: w[6:0] = `OPC_AUIPC;
                default: w[6:0] = `OPC_LOAD;
            endcase
        end else begin
            case (s[1:0])
                2'd0: w[6:0] = s[3] ? (s[2] ? 7'b0001111 : 7'b1110011) : 7'b0101111;
                2'd1: w = {1'b1, s[9:4], w[24:7], `OPC_OP};
                2'd2: w[1:0] = {1'b0, s[4]};
                default: w = {1'b1, s[9:4], w[24:7], `OPC_OP32};
            endcase
        end
    endtask

    task automatic send(input logic [31:0] w, input logic v);
        @(posedge i_clk);
        #2;
        i_valid = v;
        i_inst = w;
        i_inst_pc = pc;
        i_inst_npc = pc + 64'd4;
        if (v) begin
            exp_q.push_back(ref_decode(w, pc));
            pc = pc + 64'd4;
        end
    endtask

    task automatic run_test(input string name, input int kind, input int items, input bit gaps);
        logic [31:0] w;
        logic [31:0] g;
        test_errs = 0;
        checked = 0;
        for (int i = 0; i < items; i++) begin
            gen_inst(kind, w);
            g = $random(seed);
            if (gaps && g[0]) send(32'd0, 1'b0);
            send(w, 1'b1);
        end
        send(32'd0, 1'b0);
        while (exp_q.size() != 0) @(posedge i_clk);
        $display("%-14s %0d checked, %0d errors", name, checked, test_errs);
    endtask

    task automatic check_field(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("ERR time=%0t %s exp=%h act=%h", $time, name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    always @(negedge i_clk) begin
        decinfo_t e;
        if (!i_rst && o_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("o_valid rose with no instruction outstanding at %0t", $time);
                errors++;
                test_errs++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                held = e;
                checked++;
                check_field("pc", e.pc, o_decinfo.pc);
                check_field("npc", e.npc, o_decinfo.npc);
                check_field("imm20", 64'(e.imm20), 64'(o_decinfo.imm20));
                check_field("rd_wen", 64'(e.rd_wen), 64'(o_decinfo.rd_wen));
                check_field("rd_idx", 64'(e.rd_idx), 64'(o_decinfo.rd_idx));
                check_field("rs1_idx", 64'(e.rs1_idx), 64'(o_decinfo.rs1_idx));
                check_field("rs2_idx", 64'(e.rs2_idx), 64'(o_decinfo.rs2_idx));
                check_field("use_imm", 64'(e.use_imm), 64'(o_decinfo.use_imm));
                check_field("is_mv", 64'(e.is_mv), 64'(o_decinfo.is_mv));
                check_field("disp_que", 64'(e.disp_que), 64'(o_decinfo.disp_que));
                check_field("issue_que", 64'(e.issue_que), 64'(o_decinfo.issue_que));
                check_field("micop", 64'(e.micop.alu), 64'(o_decinfo.micop.alu));
            end
        end else if (!i_rst) begin
            // record stays put through a gap
            assert (o_decinfo === held) else begin
                $display("ERR time=%0t o_decinfo exp=%h act=%h", $time, held, o_decinfo);
                errors++;
                test_errs++;
            end
        end
    end

    initial begin
        seed = 41417;
        cycles = 0;
        errors = 0;
        held = '0;
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_valid = 1'b0;
        i_inst = '0;
        i_inst_pc = '0;
        i_inst_npc = '0;
        pc = 64'h8000_0000;
        repeat (3) @(posedge i_clk);
        #2;
        i_rst = 1'b0;
        @(negedge i_clk);
        assert (!o_valid && o_decinfo == '0) else begin
            $display("outputs not cleared by reset");
            errors++;
        end
        run_test("reset_latency", 4, ITEMS / 2, 1'b1);
        run_test("integer_alu", 0, ITEMS, 1'b0);
        run_test("muldiv", 1, ITEMS, 1'b0);
        run_test("immediates", 2, ITEMS, 1'b0);
        run_test("unknown", 3, ITEMS, 1'b0);
        run_test("random_mix", 4, ITEMS, 1'b0);
        $display("tests %0d, errors %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/decode_pkg.sv
decoder/inst_classify.sv
decoder/imm_gen.sv
decoder/micop_gen.sv
decoder/operand_gen.sv
src/decode_stage.sv
dv/decode_stage_assert.sv
dv/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decode_stage_tb \
    -f verilog.f -o decode_stage_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/decode_stage_sim > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
